// File: dcache_top.f
+incdir+hdl
hdl/dcache_geom_pkg.sv
hdl/dcache_bus_pkg.sv
hdl/dcache_sdpram.sv
hdl/dcache_lru.sv
hdl/dcache_tag_store.sv
hdl/dcache_data_store.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
tests/tb_dcache.sv

// File: hdl/dcache_bus_pkg.sv
// Cache port structs
`default_nettype none
`include "dcache_params.svh"

package dcache_bus_pkg;
   import dcache_geom_pkg::*;

   // CPU request, held until acknowledged
   typedef struct packed {
      logic                     req;
      logic                     we;
      dc_addr_t                 adr;
      logic [`DC_DAT_W-1:0]     dat;
      logic [`DC_DAT_W/8-1:0]   bsel;
   } dc_cpu_req_t;

   // One refill word from memory
   typedef struct packed {
      logic                 we;
      dc_addr_t             adr;
      logic [`DC_DAT_W-1:0] dat;
   } dc_refill_t;

   // SPR bus access
   typedef struct packed {
      logic                 stb;
      logic                 we;
      logic [15:0]          addr;
      logic [`DC_DAT_W-1:0] dat;
   } dc_spr_req_t;

endpackage

`default_nettype wire

// File: hdl/dcache_ctrl.sv
// Cache control FSM
`timescale 1ns/1ps
`default_nettype none
`include "dcache_params.svh"

module dcache_ctrl
   import dcache_geom_pkg::*;
   import dcache_bus_pkg::*;
(
   input  logic         clk,
   input  logic         rst,
   input  dc_cpu_req_t  cpu_req_i,
   input  dc_refill_t   refill_i,
   input  dc_spr_req_t  spr_i,
   input  dc_way_sel_t  hit_i,
   input  dc_way_sel_t  saved_victim_i,
   output logic         cpu_ack_o,
   output logic         refill_req_o,
   output dc_addr_t     refill_adr_o,
   output logic         spr_ack_o,
   output logic         tag_we_o,
   output dc_set_t      tag_windex_o,
   output dc_tag_wsel_e tag_wsel_o,
   output dc_way_sel_t  way_we_o,
   output logic         src_sel_o,
   output dc_word_idx_t waddr_o,
   output dc_way_sel_t  access_o
);

   localparam int CNT_W = $clog2(`DC_WORDS);
   localparam logic [CNT_W-1:0] WORD_LAST = CNT_W'(`DC_WORDS - 1);

   // One-hot states
   typedef enum logic [4:0] {
      S_IDLE       = 5'b00001,
      S_READ       = 5'b00010,
      S_WRITE      = 5'b00100,
      S_REFILL     = 5'b01000,
      S_INVALIDATE = 5'b10000
   } state_e;

   state_e           state;
   dc_addr_t         miss_adr;
   dc_set_t          inv_set;
   logic [CNT_W-1:0] word_cnt;
   logic             inv_req;
   logic             hit;
   logic             first_word;
   logic             last_word;

   // Block flush and block invalidate both clear the set
   assign inv_req = spr_i.stb && spr_i.we &&
                    ((spr_i.addr == `DC_SPR_DCBFR) || (spr_i.addr == `DC_SPR_DCBIR));

   assign hit        = |hit_i;
   assign first_word = refill_i.we && (word_cnt == '0);
   assign last_word  = refill_i.we && (word_cnt == WORD_LAST);

   assign refill_req_o = (state == S_REFILL);
   assign refill_adr_o = miss_adr;
   assign spr_ack_o    = (state == S_IDLE) || (state == S_INVALIDATE);

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= S_IDLE;
         cpu_ack_o <= 1'b0;
         word_cnt  <= '0;
      end else begin
         cpu_ack_o <= 1'b0;
         case (state)
            S_IDLE: begin
               // Invalidate first; skip the request just acknowledged
               if (inv_req) begin
                  state <= S_INVALIDATE;
               end else if (cpu_req_i.req && !cpu_ack_o) begin
                  state <= cpu_req_i.we ? S_WRITE : S_READ;
               end
            end
            S_READ: begin
               if (hit) begin
                  cpu_ack_o <= 1'b1;
                  state     <= S_IDLE;
               end else begin
                  state <= S_REFILL;
               end
            end
            S_WRITE: begin
               // Write miss is acknowledged without allocation
               cpu_ack_o <= 1'b1;
               state     <= S_IDLE;
            end
            S_REFILL: begin
               if (refill_i.we) begin
                  // Counter wraps back to zero on the last word
                  word_cnt <= word_cnt + 1'b1;
                  if (last_word) begin
                     state <= S_IDLE;
                  end
               end
            end
            S_INVALIDATE: begin
               if (!inv_req) begin
                  state <= S_IDLE;
               end
            end
            default: begin
               state <= S_IDLE;
            end
         endcase
      end
   end

   // Miss address and invalidate set
   always_ff @(posedge clk) begin
      if ((state == S_READ) && !hit) begin
         miss_adr <= cpu_req_i.adr;
      end
      if (inv_req && spr_ack_o) begin
         inv_set <= spr_i.dat[`DC_SET_W+`DC_BLOCK_W-1:`DC_BLOCK_W];
      end
   end

   // Tag and way RAM controls
   always_comb begin
      tag_we_o     = 1'b0;
      tag_wsel_o   = TW_KEEP;
      tag_windex_o = cpu_req_i.adr.set;
      way_we_o     = '0;
      src_sel_o    = 1'b0;
      waddr_o      = {cpu_req_i.adr.set, cpu_req_i.adr.word};
      access_o     = '0;
      case (state)
         S_READ: begin
            if (hit) begin
               access_o   = hit_i;
               tag_wsel_o = TW_LRU;
               tag_we_o   = 1'b1;
            end
         end
         S_WRITE: begin
            if (hit) begin
               access_o   = hit_i;
               way_we_o   = hit_i;
               tag_wsel_o = TW_LRU;
               tag_we_o   = 1'b1;
            end
         end
         S_REFILL: begin
            tag_windex_o = miss_adr.set;
            waddr_o      = {refill_i.adr.set, refill_i.adr.word};
            src_sel_o    = 1'b1;
            if (refill_i.we) begin
               way_we_o = saved_victim_i;
               access_o = saved_victim_i;
               if (first_word) begin
                  tag_wsel_o = TW_VICTIM_INV;
                  tag_we_o   = 1'b1;
               end
               if (last_word) begin
                  tag_wsel_o = TW_REFILL_DONE;
                  tag_we_o   = 1'b1;
               end
            end
         end
         S_INVALIDATE: begin
            tag_windex_o = inv_set;
            tag_wsel_o   = TW_CLEAR;
            tag_we_o     = 1'b1;
         end
         default: begin
         end
      endcase
   end

   a_state_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(state))
      else $error("dcache_ctrl: state is not one-hot");

   // Acknowledge is registered, so it trails the state by a cycle
   a_no_ack_in_refill: assert property (@(posedge clk) disable iff (rst)
      (state == S_REFILL) |-> !cpu_ack_o)
      else $error("dcache_ctrl: acknowledge during refill");

   // Memory only answers an open refill request
   a_refill_in_refill: assert property (@(posedge clk) disable iff (rst)
      refill_i.we |-> (state == S_REFILL))
      else $error("dcache_ctrl: refill word outside refill");

endmodule

`default_nettype wire

// File: hdl/dcache_data_store.sv
// Data ways with byte merge
`timescale 1ns/1ps
`default_nettype none
`include "dcache_params.svh"

module dcache_data_store
   import dcache_geom_pkg::*;
(
   input  logic                   clk,
   input  dc_word_idx_t           raddr_i,
   input  dc_word_idx_t           waddr_i,
   input  dc_way_sel_t            way_we_i,
   input  logic                   src_sel_i,
   input  logic [`DC_DAT_W-1:0]   cpu_dat_i,
   input  logic [`DC_DAT_W/8-1:0] bsel_i,
   input  logic [`DC_DAT_W-1:0]   refill_dat_i,
   input  dc_way_sel_t            hit_i,
   output logic [`DC_DAT_W-1:0]   dat_o
);

   logic [`DC_DAT_W-1:0] dout [`DC_WAYS];
   logic [`DC_DAT_W-1:0] cpu_wdat;
   logic [`DC_DAT_W-1:0] wdat;

   // One RAM per way, shared write data
   for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
      dcache_sdpram #(
         .ADDR_W ($bits(dc_word_idx_t)),
         .DATA_W (`DC_DAT_W)
      ) u_way_ram (
         .clk     (clk),
         .raddr_i (raddr_i),
         .waddr_i (waddr_i),
         .we_i    (way_we_i[w]),
         .din_i   (wdat),
         .dout_o  (dout[w])
      );
   end

   // Hit way onto the read port
   always_comb begin
      dat_o = '0;
      for (int w = 0; w < `DC_WAYS; w++) begin
         if (hit_i[w]) begin
            dat_o = dout[w];
         end
      end
   end

   // Unselected bytes keep the word already in the hit way
   always_comb begin
      for (int b = 0; b < `DC_DAT_W/8; b++) begin
         cpu_wdat[8*b +: 8] = bsel_i[b] ? cpu_dat_i[8*b +: 8] : dat_o[8*b +: 8];
      end
   end

   // Refill words go in whole
   assign wdat = src_sel_i ? refill_dat_i : cpu_wdat;

endmodule

`default_nettype wire

// File: hdl/dcache_geom_pkg.sv
// Cache array types
`default_nettype none
`include "dcache_params.svh"

package dcache_geom_pkg;

   typedef logic [`DC_TAG_W-1:0]   dc_tag_t;
   typedef logic [`DC_SET_W-1:0]   dc_set_t;
   typedef logic [`DC_BLOCK_W-3:0] dc_word_t;
   typedef logic                   dc_lru_t;

   // Way RAM address, set then word in block
   typedef logic [`DC_SET_W+`DC_BLOCK_W-3:0] dc_word_idx_t;

   // One-hot way vector
   typedef logic [`DC_WAYS-1:0] dc_way_sel_t;

   // CPU byte address split into its cache fields
   typedef struct packed {
      dc_tag_t    tag;
      dc_set_t    set;
      dc_word_t   word;
      logic [1:0] boff;
   } dc_addr_t;

   // One way inside a tag RAM word
   typedef struct packed {
      logic    valid;
      dc_tag_t tag;
   } dc_tag_way_t;

   // Tag RAM word, LRU bit on top
   typedef struct packed {
      dc_lru_t                   lru;
      dc_tag_way_t [`DC_WAYS-1:0] way;
   } dc_tag_line_t;

   // What goes into the tag RAM on a write
   typedef enum logic [2:0] {
      TW_KEEP,
      TW_LRU,
      TW_VICTIM_INV,
      TW_REFILL_DONE,
      TW_CLEAR
   } dc_tag_wsel_e;

endpackage

`default_nettype wire

// File: hdl/dcache_lru.sv
// Two-way LRU history
`timescale 1ns/1ps
`default_nettype none

module dcache_lru
   import dcache_geom_pkg::*;
(
   input  dc_lru_t     cur_i,
   input  dc_way_sel_t access_i,
   output dc_lru_t     next_o,
   output dc_way_sel_t victim_o
);

   // History bit holds the index of the most recently used way
   always_comb begin
      if (access_i == '0) begin
         // No access, history stays
         next_o = cur_i;
      end else begin
         // Accessed way becomes the most recent one
         next_o = access_i[1];
      end
   end

   // Replace the way that was not used last
   always_comb begin
      victim_o = '0;
      victim_o[~cur_i] = 1'b1;
   end

   // Access comes from a hit vector or a saved victim
   always_comb begin
      if (!$isunknown(access_i)) begin
         a_access_onehot0: assert ($onehot0(access_i))
            else $error("dcache_lru: access vector is not one-hot");
      end
   end

endmodule

`default_nettype wire

// File: hdl/dcache_params.svh
// Data cache geometry
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// Address and data widths
`define DC_ADR_W 32
`define DC_DAT_W 32

// Block geometry, 16 bytes per block and 64 sets
`define DC_BLOCK_W 4
`define DC_SET_W 6
`define DC_WAYS 2

// Tag is whatever sits left of the index
`define DC_TAG_W (`DC_ADR_W - `DC_SET_W - `DC_BLOCK_W)
`define DC_WORDS (1 << (`DC_BLOCK_W - 2))

// SPR numbers of block flush and block invalidate
`define DC_SPR_DCBFR 16'h3002
`define DC_SPR_DCBIR 16'h3003

// Forward write data to a read of the same address
`define DC_RAM_BYPASS 1'b1

`endif

// File: hdl/dcache_sdpram.sv
// Simple dual-port RAM
`timescale 1ns/1ps
`default_nettype none
`include "dcache_params.svh"

module dcache_sdpram #(
   parameter int ADDR_W = 6,
   parameter int DATA_W = 32
) (
   input  logic              clk,
   input  logic [ADDR_W-1:0] raddr_i,
   input  logic [ADDR_W-1:0] waddr_i,
   input  logic              we_i,
   input  logic [DATA_W-1:0] din_i,
   output logic [DATA_W-1:0] dout_o
);

   logic [DATA_W-1:0] mem [1 << ADDR_W];

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= din_i;
      end
      // Same-cycle write to the read address wins when bypass is on
      if (`DC_RAM_BYPASS && we_i && (waddr_i == raddr_i)) begin
         dout_o <= din_i;
      end else begin
         dout_o <= mem[raddr_i];
      end
   end

   // An unknown write enable would smear X over the array
   a_we_known: assert property (@(posedge clk) !$isunknown(we_i))
      else $error("dcache_sdpram: write enable is unknown");

endmodule

`default_nettype wire

// File: hdl/dcache_tag_store.sv
// Tag store and way compare
`timescale 1ns/1ps
`default_nettype none
`include "dcache_params.svh"

module dcache_tag_store
   import dcache_geom_pkg::*;
(
   input  logic         clk,
   input  dc_set_t      rindex_i,
   input  dc_set_t      windex_i,
   input  logic         we_i,
   input  dc_tag_wsel_e wsel_i,
   input  dc_tag_t      cmp_tag_i,
   input  dc_tag_t      refill_tag_i,
   input  dc_lru_t      lru_next_i,
   input  dc_way_sel_t  victim_i,
   output dc_way_sel_t  hit_o,
   output dc_lru_t      lru_cur_o,
   output dc_way_sel_t  saved_victim_o
);

   dc_tag_line_t rline;
   dc_tag_line_t wline;
   dc_tag_line_t saved_line;

   dcache_sdpram #(
      .ADDR_W (`DC_SET_W),
      .DATA_W ($bits(dc_tag_line_t))
   ) u_tag_ram (
      .clk     (clk),
      .raddr_i (rindex_i),
      .waddr_i (windex_i),
      .we_i    (we_i),
      .din_i   (wline),
      .dout_o  (rline)
   );

   assign lru_cur_o = rline.lru;

   // Valid entry with equal tag
   always_comb begin
      for (int w = 0; w < `DC_WAYS; w++) begin
         hit_o[w] = rline.way[w].valid && (rline.way[w].tag == cmp_tag_i);
      end
   end

   // Snapshot follows the RAM while nothing is written,
   // so it holds the missed set once the refill begins
   always_ff @(posedge clk) begin
      if (!we_i) begin
         saved_line     <= rline;
         saved_victim_o <= victim_i;
      end
   end

   always_comb begin
      wline = rline;
      case (wsel_i)
         TW_LRU: begin
            wline.lru = lru_next_i;
         end
         TW_VICTIM_INV: begin
            // Victim goes invalid before its data is overwritten
            wline = saved_line;
            for (int w = 0; w < `DC_WAYS; w++) begin
               if (saved_victim_o[w]) begin
                  wline.way[w].valid = 1'b0;
               end
            end
         end
         TW_REFILL_DONE: begin
            wline = saved_line;
            for (int w = 0; w < `DC_WAYS; w++) begin
               if (saved_victim_o[w]) begin
                  wline.way[w] = '{valid: 1'b1, tag: refill_tag_i};
               end
            end
            wline.lru = lru_next_i;
         end
         TW_CLEAR: begin
            wline = '0;
         end
         default: begin
            wline = rline;
         end
      endcase
   end

   // A block never lives in both ways of a set
   a_hit_onehot0: assert property (@(posedge clk)
      !$isunknown(hit_o) |-> $onehot0(hit_o))
      else $error("dcache_tag_store: both ways hit");

endmodule

`default_nettype wire

// File: hdl/dcache_top.sv
// Data cache top level
`timescale 1ns/1ps
`default_nettype none
`include "dcache_params.svh"

module dcache_top
   import dcache_geom_pkg::*;
   import dcache_bus_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  dc_cpu_req_t          cpu_req_i,
   input  dc_refill_t           refill_i,
   input  dc_spr_req_t          spr_i,
   output logic                 cpu_ack_o,
   output logic [`DC_DAT_W-1:0] cpu_dat_o,
   output logic                 refill_req_o,
   output dc_addr_t             refill_adr_o,
   output logic                 spr_ack_o
);

   dc_way_sel_t  hit;
   dc_way_sel_t  saved_victim;
   dc_way_sel_t  victim;
   dc_way_sel_t  way_we;
   dc_way_sel_t  access;
   dc_lru_t      lru_cur;
   dc_lru_t      lru_next;
   logic         tag_we;
   dc_set_t      tag_windex;
   dc_tag_wsel_e tag_wsel;
   logic         src_sel;
   dc_word_idx_t waddr;
   dc_word_idx_t raddr;

   // Ways are read at the held request address
   assign raddr = {cpu_req_i.adr.set, cpu_req_i.adr.word};

   dcache_ctrl u_ctrl (
      .clk            (clk),
      .rst            (rst),
      .cpu_req_i      (cpu_req_i),
      .refill_i       (refill_i),
      .spr_i          (spr_i),
      .hit_i          (hit),
      .saved_victim_i (saved_victim),
      .cpu_ack_o      (cpu_ack_o),
      .refill_req_o   (refill_req_o),
      .refill_adr_o   (refill_adr_o),
      .spr_ack_o      (spr_ack_o),
      .tag_we_o       (tag_we),
      .tag_windex_o   (tag_windex),
      .tag_wsel_o     (tag_wsel),
      .way_we_o       (way_we),
      .src_sel_o      (src_sel),
      .waddr_o        (waddr),
      .access_o       (access)
   );

   dcache_tag_store u_tag_store (
      .clk            (clk),
      .rindex_i       (cpu_req_i.adr.set),
      .windex_i       (tag_windex),
      .we_i           (tag_we),
      .wsel_i         (tag_wsel),
      .cmp_tag_i      (cpu_req_i.adr.tag),
      .refill_tag_i   (refill_adr_o.tag),
      .lru_next_i     (lru_next),
      .victim_i       (victim),
      .hit_o          (hit),
      .lru_cur_o      (lru_cur),
      .saved_victim_o (saved_victim)
   );

   dcache_data_store u_data_store (
      .clk          (clk),
      .raddr_i      (raddr),
      .waddr_i      (waddr),
      .way_we_i     (way_we),
      .src_sel_i    (src_sel),
      .cpu_dat_i    (cpu_req_i.dat),
      .bsel_i       (cpu_req_i.bsel),
      .refill_dat_i (refill_i.dat),
      .hit_i        (hit),
      .dat_o        (cpu_dat_o)
   );

   dcache_lru u_lru (
      .cur_i    (lru_cur),
      .access_i (access),
      .next_o   (lru_next),
      .victim_o (victim)
   );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   -f dcache_top.f --top-module tb_dcache --Mdir "$BUILD_DIR" -o tb_dcache
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

"./$BUILD_DIR/tb_dcache" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Everything OK" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: tests/tb_dcache.sv
// Data cache testbench
`timescale 1ns/1ps
`default_nettype none
`include "dcache_params.svh"

module tb_dcache
   import dcache_geom_pkg::*;
   import dcache_bus_pkg::*;
();

   localparam int WAIT_LIMIT = 200;
   // Refill expectation of a read
   localparam int MUST_HIT   = 0;
   localparam int MUST_MISS  = 1;
   localparam int EITHER     = 2;

   logic                 clk;
   logic                 rst;
   dc_cpu_req_t          cpu_req;
   dc_refill_t           refill;
   dc_spr_req_t          spr;
   logic                 cpu_ack;
   logic [`DC_DAT_W-1:0] cpu_dat;
   logic                 refill_req;
   dc_addr_t             refill_adr;
   logic                 spr_ack;

   // Memory contents, keyed by word address
   logic [31:0] mem_model [logic [29:0]];

   dcache_top UUT (
      .clk          (clk),
      .rst          (rst),
      .cpu_req_i    (cpu_req),
      .refill_i     (refill),
      .spr_i        (spr),
      .cpu_ack_o    (cpu_ack),
      .cpu_dat_o    (cpu_dat),
      .refill_req_o (refill_req),
      .refill_adr_o (refill_adr),
      .spr_ack_o    (spr_ack)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic stop_run();
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic value_error(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      stop_run();
   endtask

   task automatic fail_with(input string what);
      $display("Failure at %0t: %s", $time, what);
      stop_run();
   endtask

   // Untouched memory, a rotated and masked copy of the word address
   function automatic logic [31:0] fill_word(input logic [29:0] wa);
      return {wa[17:0], wa[29:18], 2'b01} ^ 32'h6c8e_9cf5;
   endfunction

   function automatic logic [31:0] model_read(input logic [29:0] wa);
      if (mem_model.exists(wa)) begin
         return mem_model[wa];
      end
      return fill_word(wa);
   endfunction

   // Write-through memory takes every store, hit or miss
   task automatic model_write(input logic [29:0] wa, input logic [31:0] dat,
                              input logic [3:0] bsel);
      logic [31:0] word;
      word = model_read(wa);
      for (int b = 0; b < 4; b++) begin
         if (bsel[b]) begin
            word[8*b +: 8] = dat[8*b +: 8];
         end
      end
      mem_model[wa] = word;
   endtask

   // Four words in wrapping order from the missed word, random gaps
   task automatic serve_refill();
      dc_addr_t base;
      dc_addr_t wadr;
      int       gap;
      base = refill_adr;
      for (int i = 0; i < `DC_WORDS; i++) begin
         gap = int'($urandom_range(3, 0));
         repeat (gap) begin
            @(posedge clk);
            #1;
            refill.we = 1'b0;
         end
         @(posedge clk);
         #1;
         wadr       = base;
         wadr.word  = base.word + dc_word_t'(i);
         wadr.boff  = 2'b00;
         refill.we  = 1'b1;
         refill.adr = wadr;
         refill.dat = model_read(wadr[31:2]);
      end
      @(posedge clk);
      #1;
      refill.we = 1'b0;
   endtask

   task automatic cpu_read(input logic [31:0] addr, input int mode);
      int          cycles;
      int          refills;
      logic [31:0] exp;
      exp          = model_read(addr[31:2]);
      cpu_req.req  = 1'b1;
      cpu_req.we   = 1'b0;
      cpu_req.adr  = addr;
      cpu_req.dat  = '0;
      cpu_req.bsel = '0;
      cycles       = 0;
      refills      = 0;
      @(negedge clk);
      while (!cpu_ack) begin
         if (refill_req) begin
            refills++;
            assert (refill_adr[31:2] == addr[31:2])
               else value_error("refill_adr_o", refill_adr, {addr[31:2], 2'b00});
            serve_refill();
         end
         assert (cycles < WAIT_LIMIT) else fail_with("read was never acknowledged");
         @(negedge clk);
         cycles++;
      end
      assert (cpu_dat === exp) else value_error("cpu_dat_o", cpu_dat, exp);
      if (mode == MUST_HIT) begin
         assert (refills == 0) else fail_with("read expected to hit caused a refill");
         assert (cycles == 2) else value_error("read hit latency", cycles, 2);
      end else if (mode == MUST_MISS) begin
         assert (refills == 1) else value_error("refill count", refills, 1);
      end else begin
         assert (refills <= 1) else fail_with("one read caused several refills");
      end
      @(posedge clk);
      #1;
      cpu_req.req = 1'b0;
   endtask

   task automatic cpu_write(input logic [31:0] addr, input logic [31:0] dat,
                            input logic [3:0] bsel);
      int cycles;
      cpu_req.req  = 1'b1;
      cpu_req.we   = 1'b1;
      cpu_req.adr  = addr;
      cpu_req.dat  = dat;
      cpu_req.bsel = bsel;
      cycles       = 0;
      @(negedge clk);
      while (!cpu_ack) begin
         // No allocation on writes
         assert (!refill_req) else fail_with("write raised a refill request");
         assert (cycles < WAIT_LIMIT) else fail_with("write was never acknowledged");
         @(negedge clk);
         cycles++;
      end
      assert (cycles == 2) else value_error("write ack latency", cycles, 2);
      model_write(addr[31:2], dat, bsel);
      @(posedge clk);
      #1;
      cpu_req.req = 1'b0;
      cpu_req.we  = 1'b0;
   endtask

   // Strobe stays up after return, so writes can follow back to back
   task automatic spr_write(input logic [15:0] num, input logic [31:0] dat);
      int waited;
      spr.stb  = 1'b1;
      spr.we   = 1'b1;
      spr.addr = num;
      spr.dat  = dat;
      waited   = 0;
      @(negedge clk);
      while (!spr_ack) begin
         waited++;
         assert (waited < WAIT_LIMIT) else fail_with("spr_ack_o stayed low");
         @(negedge clk);
      end
      @(posedge clk);
      #1;
   endtask

   // Drop the strobe and let the last invalidate finish
   task automatic spr_release();
      spr.stb = 1'b0;
      spr.we  = 1'b0;
      @(posedge clk);
      #1;
   endtask

   initial begin
      logic [31:0] radr;
      rst     = 1'b1;
      cpu_req = '0;
      refill  = '0;
      spr     = '0;
      void'($urandom(32'hfa19098d));
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;

      // Idle outputs after reset
      @(negedge clk);
      assert (cpu_ack == 1'b0) else value_error("cpu_ack_o", cpu_ack, 0);
      assert (refill_req == 1'b0) else value_error("refill_req_o", refill_req, 0);
      assert (spr_ack == 1'b1) else value_error("spr_ack_o", spr_ack, 1);
      @(posedge clk);
      #1;

      // Tag RAM starts unknown, clear every set
      for (int s = 0; s < (1 << `DC_SET_W); s++) begin
         spr_write(`DC_SPR_DCBIR, 32'(s) << `DC_BLOCK_W);
      end
      spr_release();

      // Fresh block, missed word in the middle of the block
      cpu_read(32'h0000_0458, MUST_MISS);
      // Rest of the block hits
      cpu_read(32'h0000_0450, MUST_HIT);
      cpu_read(32'h0000_0454, MUST_HIT);
      cpu_read(32'h0000_045c, MUST_HIT);
      cpu_read(32'h0000_0458, MUST_HIT);

      // Partial write hit, middle bytes only
      cpu_write(32'h0000_0454, 32'ha1b2_c3d4, 4'b0110);
      cpu_read(32'h0000_0454, MUST_HIT);

      // Set 5 with A, B then C, B is least recent when C arrives
      cpu_read(32'h0000_0850, MUST_MISS);
      cpu_read(32'h0000_0450, MUST_HIT);
      cpu_read(32'h0000_0c50, MUST_MISS);
      cpu_read(32'h0000_0450, MUST_HIT);
      cpu_read(32'h0000_0850, MUST_MISS);

      // Block invalidate clears the set
      spr_write(`DC_SPR_DCBIR, 32'h0000_0450);
      spr_release();
      cpu_read(32'h0000_0450, MUST_MISS);
      // Block flush does the same
      cpu_read(32'h0000_1090, MUST_MISS);
      spr_write(`DC_SPR_DCBFR, 32'h0000_1090);
      spr_release();
      cpu_read(32'h0000_1090, MUST_MISS);
      // Unrelated register number leaves the block alone
      spr_write(16'h3001, 32'h0000_1090);
      spr_release();
      cpu_read(32'h0000_1090, MUST_HIT);

      // Three tags over four sets, so blocks keep getting evicted
      for (int n = 0; n < 300; n++) begin
         radr = 32'h0010_0000 | ($urandom_range(2, 0) << 10) |
                ($urandom_range(3, 0) << 4) | ($urandom_range(3, 0) << 2);
         if ($urandom_range(1, 0) == 1) begin
            cpu_read(radr, EITHER);
         end else begin
            cpu_write(radr, $urandom(), 4'($urandom_range(15, 1)));
         end
      end

      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire
